// ==== common/uart_pkg.sv ====
package uart_pkg;

   typedef logic [7:0]  uart_byte_t;  // One character on the line
   typedef logic [3:0]  reg_addr_t;
   typedef logic [31:0] count_t;      // Counters and bit period

   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;
   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

   // Receiver output toward the top level
   typedef struct packed {
      logic       valid;  // One-cycle pulse per good frame
      logic       brk;    // Held until next confirmed start bit
      uart_byte_t data;
   } rx_event_t;

   // Register map
   localparam reg_addr_t REG_DR              = 4'd0;
   localparam reg_addr_t REG_CTRL            = 4'd1;
   localparam reg_addr_t REG_RSTAT           = 4'd2;
   localparam reg_addr_t REG_TSTAT           = 4'd3;
   localparam reg_addr_t REG_CPB             = 4'd4;
   localparam reg_addr_t REG_QUEUE           = 4'd5;
   localparam reg_addr_t REG_POP             = 4'd6;  // Any write pops the FIFO
   localparam reg_addr_t REG_CHAR_COUNT      = 4'd7;
   localparam reg_addr_t REG_FIFO_WR_COUNT   = 4'd8;
   localparam reg_addr_t REG_FIFO_FULL_COUNT = 4'd9;
   localparam reg_addr_t REG_SCRATCH         = 4'd12; // First of four, 12 to 15

   // Control bits
   localparam int CTRL_RX_EN = 0;
   localparam int CTRL_TX_EN = 1;

   // Receive status bits and fields
   localparam int RSTAT_NOT_EMPTY = 0;
   localparam int RSTAT_BREAK     = 1;
   localparam int RSTAT_FULL      = 2;
   localparam int RSTAT_EMPTY     = 3;
   localparam int RSTAT_HEAD_LSB  = 8;
   localparam int RSTAT_WADDR_LSB = 16;
   localparam int RSTAT_RADDR_LSB = 24;

   // Transmit status
   localparam int TSTAT_TC = 0;  // Transmitter not busy

endpackage

// ==== verilog/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo
#(
   parameter int WIDTH      = 8,
   parameter int ADDR_WIDTH = 7
)
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  wr,
   input  logic                  rd,
   input  logic [WIDTH-1:0]      din,
   output logic [WIDTH-1:0]      dout,
   output logic                  empty,
   output logic                  full,
   output logic [ADDR_WIDTH-1:0] raddr,
   output logic [ADDR_WIDTH-1:0] waddr
);
   localparam int DEPTH = 2 ** ADDR_WIDTH;

   logic [WIDTH-1:0]    mem [DEPTH];
   logic [ADDR_WIDTH:0] wptr;  // MSB is the wrap bit
   logic [ADDR_WIDTH:0] rptr;
   logic                do_wr;
   logic                do_rd;

   assign raddr = rptr[ADDR_WIDTH-1:0];
   assign waddr = wptr[ADDR_WIDTH-1:0];
   assign empty = (wptr == rptr);
   assign full  = (waddr == raddr) & (wptr[ADDR_WIDTH] != rptr[ADDR_WIDTH]);
   assign do_wr = wr & ~full;   // Overflow drops the byte
   assign do_rd = rd & ~empty;
   assign dout  = mem[raddr];   // Head entry

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wptr <= '0;
         rptr <= '0;
      end
      else
      begin
         if (do_wr)
            wptr <= wptr + 1'b1;
         if (do_rd)
            rptr <= rptr + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (do_wr)
         mem[waddr] <= din;
   end

   a_not_empty_and_full: assert property (
      @(posedge clk) disable iff (reset)
      !(empty && full));

endmodule

// ==== uart/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 start,
   input  uart_pkg::uart_byte_t data,
   input  uart_pkg::count_t     cycles_per_bit,
   output logic                 busy,
   output logic                 txd
);
   import uart_pkg::*;

   tx_state_t  state;
   count_t     bit_cnt;  // Cycles spent in current bit
   logic [2:0] bit_idx;
   uart_byte_t shift;
   logic       bit_done;

   assign bit_done = (bit_cnt == cycles_per_bit - count_t'(1));
   assign busy     = (state != TX_IDLE);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state   <= TX_IDLE;
         bit_cnt <= '0;
         bit_idx <= '0;
         txd     <= 1'b1;
      end
      else
      begin
         bit_cnt <= bit_done ? '0 : bit_cnt + count_t'(1);
         case (state)
            TX_IDLE:
            begin
               bit_cnt <= '0;
               if (start)
               begin
                  state <= TX_START;
                  txd   <= 1'b0;  // Start bit
               end
            end
            TX_START:
               if (bit_done)
               begin
                  state   <= TX_DATA;
                  bit_idx <= '0;
                  txd     <= shift[0];
               end
            TX_DATA:
               if (bit_done)
               begin
                  if (bit_idx == 3'd7)
                  begin
                     state <= TX_STOP;
                     txd   <= 1'b1;  // Stop bit
                  end
                  else
                  begin
                     bit_idx <= bit_idx + 3'd1;
                     txd     <= shift[0];
                  end
               end
            TX_STOP:
               if (bit_done)
                  state <= TX_IDLE;
            default: state <= TX_IDLE;
         endcase
      end
   end

   // Byte captured while idle, LSB first afterwards
   always_ff @(posedge clk)
   begin
      if (state == TX_IDLE)
         shift <= data;
      else if (bit_done)
         shift <= shift >> 1;
   end

   a_idle_line_high: assert property (
      @(posedge clk) disable iff (reset)
      (state == TX_IDLE) |-> txd);

endmodule

// ==== uart/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx
(
   input  logic                clk,
   input  logic                reset,
   input  logic                rxd,
   input  logic                en,
   input  uart_pkg::count_t    cycles_per_bit,
   output uart_pkg::rx_event_t rx,
   output uart_pkg::count_t    char_count
);
   import uart_pkg::*;

   logic       rxd_meta;
   logic       rxd_sync;
   logic       rxd_last;  // For falling edge detection
   rx_state_t  state;
   count_t     cnt;
   logic [2:0] bit_idx;
   uart_byte_t shift;
   logic       valid_q;
   logic       brk_q;
   logic       half_done;
   logic       bit_done;
   logic       fall;

   assign half_done = (cnt == (cycles_per_bit >> 1) - count_t'(1));
   assign bit_done  = (cnt == cycles_per_bit - count_t'(1));
   assign fall      = rxd_last & ~rxd_sync;

   // Two-flop synchronizer, idle line is high
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
         rxd_last <= 1'b1;
      end
      else
      begin
         rxd_meta <= rxd;
         rxd_sync <= rxd_meta;
         rxd_last <= rxd_sync;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state      <= RX_IDLE;
         cnt        <= '0;
         bit_idx    <= '0;
         valid_q    <= 1'b0;
         brk_q      <= 1'b0;
         char_count <= '0;
      end
      else
      begin
         valid_q <= 1'b0;
         cnt     <= cnt + count_t'(1);
         if (!en)
         begin
            state <= RX_IDLE;
            cnt   <= '0;
         end
         else
            case (state)
               RX_IDLE:
               begin
                  cnt <= '0;
                  if (fall)
                     state <= RX_START;
               end
               RX_START:
                  if (half_done)  // Middle of start bit
                  begin
                     cnt     <= '0;
                     bit_idx <= '0;
                     if (!rxd_sync)
                     begin
                        state <= RX_DATA;
                        brk_q <= 1'b0;
                     end
                     else
                        state <= RX_IDLE;  // Glitch, not a start
                  end
               RX_DATA:
                  if (bit_done)
                  begin
                     cnt     <= '0;
                     bit_idx <= bit_idx + 3'd1;
                     if (bit_idx == 3'd7)
                        state <= RX_STOP;
                  end
               RX_STOP:
                  if (bit_done)
                  begin
                     state <= RX_IDLE;
                     if (rxd_sync)
                     begin
                        valid_q    <= 1'b1;
                        char_count <= char_count + count_t'(1);
                     end
                     else if (shift == '0)
                        brk_q <= 1'b1;  // Line held low through the frame
                  end
               default: state <= RX_IDLE;
            endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == RX_DATA && bit_done)
         shift <= {rxd_sync, shift[7:1]};  // LSB arrives first
   end

   assign rx = '{valid: valid_q, brk: brk_q, data: shift};

   a_valid_single: assert property (
      @(posedge clk) disable iff (reset)
      rx.valid |=> !rx.valid);

endmodule

// ==== uart/uart.sv ====
`timescale 1ns/1ps

module uart
#(
   parameter int               WIDTH           = 32,
   parameter int               FIFO_ADDR_WIDTH = 7,
   parameter uart_pkg::count_t RESET_CPB       = 217
)
(
   input  logic                clk,
   input  logic                reset,
   input  logic                cs,
   input  logic                wen,
   input  uart_pkg::reg_addr_t addr,
   input  logic [WIDTH-1:0]    din,
   output logic [WIDTH-1:0]    dout,
   input  logic                RxD,
   output logic                TxD
);
   import uart_pkg::*;

   logic                       wr;
   logic                       scratch_wr;
   logic                       tx_start;
   logic                       tx_busy;
   logic                       fifo_pop;
   logic [WIDTH-1:0]           control;
   count_t                     cycles_per_bit;
   logic [WIDTH-1:0]           scratch [4];
   count_t                     fifo_wr_count;
   count_t                     fifo_full_count;
   count_t                     char_count;
   rx_event_t                  rx;
   uart_byte_t                 fifo_head;
   logic                       fifo_empty;
   logic                       fifo_full;
   logic [FIFO_ADDR_WIDTH-1:0] fifo_raddr;
   logic [FIFO_ADDR_WIDTH-1:0] fifo_waddr;
   logic [WIDTH-1:0]           rstat;
   logic [WIDTH-1:0]           tstat;

   assign wr         = cs & wen;
   assign scratch_wr = wr & (addr[3:2] == REG_SCRATCH[3:2]);
   assign tx_start   = wr & (addr == REG_DR) & control[CTRL_TX_EN];
   assign fifo_pop   = wr & (addr == REG_POP);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         control        <= '0;
         cycles_per_bit <= RESET_CPB;
      end
      else if (wr)
      begin
         if (addr == REG_CTRL)
            control <= din;
         if (addr == REG_CPB)
            cycles_per_bit <= count_t'(din);
      end
   end

   // General purpose storage for software
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < 4; i++)
            scratch[i] <= '0;
      end
      else if (scratch_wr)
         scratch[addr[1:0]] <= din;
   end

   // Dropped bytes are counted separately from stored ones
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         fifo_wr_count   <= '0;
         fifo_full_count <= '0;
      end
      else if (rx.valid)
      begin
         if (fifo_full)
            fifo_full_count <= fifo_full_count + count_t'(1);
         else
            fifo_wr_count <= fifo_wr_count + count_t'(1);
      end
   end

   uart_tx u_tx
   (
      .clk            (clk),
      .reset          (reset),
      .start          (tx_start),
      .data           (din[7:0]),
      .cycles_per_bit (cycles_per_bit),
      .busy           (tx_busy),
      .txd            (TxD)
   );

   uart_rx u_rx
   (
      .clk            (clk),
      .reset          (reset),
      .rxd            (RxD),
      .en             (control[CTRL_RX_EN]),
      .cycles_per_bit (cycles_per_bit),
      .rx             (rx),
      .char_count     (char_count)
   );

   sync_fifo
   #(
      .WIDTH      ($bits(uart_byte_t)),
      .ADDR_WIDTH (FIFO_ADDR_WIDTH)
   )
   u_fifo
   (
      .clk   (clk),
      .reset (reset),
      .wr    (rx.valid),  // Receiver pulse goes straight in
      .rd    (fifo_pop),
      .din   (rx.data),
      .dout  (fifo_head),
      .empty (fifo_empty),
      .full  (fifo_full),
      .raddr (fifo_raddr),
      .waddr (fifo_waddr)
   );

   always_comb
   begin
      rstat                  = '0;
      rstat[RSTAT_NOT_EMPTY] = ~fifo_empty;
      rstat[RSTAT_BREAK]     = rx.brk;
      rstat[RSTAT_FULL]      = fifo_full;
      rstat[RSTAT_EMPTY]     = fifo_empty;
      rstat[RSTAT_HEAD_LSB +: $bits(uart_byte_t)] = fifo_head;
      rstat[RSTAT_WADDR_LSB +: FIFO_ADDR_WIDTH]   = fifo_waddr;
      rstat[RSTAT_RADDR_LSB +: FIFO_ADDR_WIDTH]   = fifo_raddr;
   end

   always_comb
   begin
      tstat           = '0;
      tstat[TSTAT_TC] = ~tx_busy;
   end

   // Read mux, no side effects
   always_comb
   begin
      dout = '0;
      case (addr)
         REG_DR, REG_QUEUE:   dout = WIDTH'(fifo_head);
         REG_CTRL:            dout = control;
         REG_RSTAT:           dout = rstat;
         REG_TSTAT:           dout = tstat;
         REG_CPB:             dout = WIDTH'(cycles_per_bit);
         REG_CHAR_COUNT:      dout = WIDTH'(char_count);
         REG_FIFO_WR_COUNT:   dout = WIDTH'(fifo_wr_count);
         REG_FIFO_FULL_COUNT: dout = WIDTH'(fifo_full_count);
         default:
            if (addr[3:2] == REG_SCRATCH[3:2])
               dout = scratch[addr[1:0]];
      endcase
   end

   // A full FIFO must not move its write pointer
   a_no_write_when_full: assert property (
      @(posedge clk) disable iff (reset)
      fifo_full |=> $stable(fifo_waddr));

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock
#(
   parameter int PERIOD_NS    = 100,
   parameter int RESET_CYCLES = 4
)
(
   output logic clk,
   output logic reset
);

   initial
   begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // Release on a falling edge, like the rest of the stimulus
   initial
   begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

endmodule

// ==== dv/uart_tb.sv ====
`timescale 1ns/1ps

module uart_tb;
   import uart_pkg::*;

   localparam int BIT_CYCLES     = 8;
   localparam int FIFO_DEPTH     = 16;     // FIFO_ADDR_WIDTH of 4
   localparam int TIMEOUT_CYCLES = 40000;  // About 60 frames of 80 cycles times 8 for margin

   logic        clk;
   logic        reset;
   logic        cs;
   logic        wen;
   reg_addr_t   addr;
   logic [31:0] din;
   logic [31:0] dout;
   logic        RxD;
   logic        TxD;

   integer      seed = 32'h6ca447d8;
   int          errors = 0;
   int          test_errors;
   int          tests_passed = 0;
   int          tests_failed = 0;
   int          cycles = 0;
   uart_byte_t  exp_q[$];    // Expected FIFO contents
   count_t      exp_chars = 0;
   count_t      exp_wr = 0;
   count_t      exp_full = 0;

   tb_clock u_clock (.clk(clk), .reset(reset));

   uart #(.FIFO_ADDR_WIDTH(4), .RESET_CPB(217)) dut
   (
      .clk   (clk),
      .reset (reset),
      .cs    (cs),
      .wen   (wen),
      .addr  (addr),
      .din   (din),
      .dout  (dout),
      .RxD   (RxD),
      .TxD   (TxD)
   );

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected)
      else
      begin
         $display("FAIL %0t %s: expected %h, got %h", $time, name, expected, actual);
         errors++;
      end
   endtask

   task automatic bus_write(input reg_addr_t a, input logic [31:0] d);
      @(negedge clk);
      cs   = 1'b1;
      wen  = 1'b1;
      addr = a;
      din  = d;
      @(negedge clk);
      cs  = 1'b0;
      wen = 1'b0;
   endtask

   // dout is combinational and settles long before the next rising edge
   task automatic bus_read(input reg_addr_t a, output logic [31:0] d);
      @(negedge clk);
      cs   = 1'b1;
      wen  = 1'b0;
      addr = a;
      #10;
      d = dout;
   endtask

   task automatic drive_bit(input logic b);
      RxD = b;
      repeat (BIT_CYCLES) @(negedge clk);
   endtask

   task automatic send_frame(input uart_byte_t value);
      @(negedge clk);
      drive_bit(1'b0);
      for (int i = 0; i < 8; i++)
         drive_bit(value[i]);  // LSB first
      drive_bit(1'b1);
      repeat (2) @(negedge clk);  // Byte lands in the FIFO
   endtask

   task automatic model_receive(input uart_byte_t value);
      exp_chars++;
      if (exp_q.size() < FIFO_DEPTH)
      begin
         exp_q.push_back(value);
         exp_wr++;
      end
      else
         exp_full++;
   endtask

   task automatic pop_and_check();
      logic [31:0] rd;
      bus_read(REG_RSTAT, rd);
      check_value("RSTAT.NOT_EMPTY", exp_q.size() > 0, rd[RSTAT_NOT_EMPTY]);
      if (exp_q.size() > 0)
      begin
         check_value("RSTAT head byte", exp_q[0], rd[RSTAT_HEAD_LSB +: 8]);
         bus_read(REG_DR, rd);
         check_value("DR", {24'b0, exp_q[0]}, rd);
         bus_read(REG_QUEUE, rd);
         check_value("QUEUE", {24'b0, exp_q[0]}, rd);
         bus_write(REG_POP, $random(seed));  // Value does not matter
         void'(exp_q.pop_front());
      end
   endtask

   task automatic check_counters();
      logic [31:0] rd;
      bus_read(REG_CHAR_COUNT, rd);
      check_value("CHAR_COUNT", exp_chars, rd);
      bus_read(REG_FIFO_WR_COUNT, rd);
      check_value("FIFO_WR_COUNT", exp_wr, rd);
      bus_read(REG_FIFO_FULL_COUNT, rd);
      check_value("FIFO_FULL_COUNT", exp_full, rd);
   endtask

   // Mid-bit sampling of one frame on TxD
   task automatic capture_tx_frame(output uart_byte_t value);
      int wait_count;
      wait_count = 0;
      value      = '0;
      while (TxD !== 1'b0 && wait_count < 4 * BIT_CYCLES)
      begin
         @(negedge clk);
         wait_count++;
      end
      assert (TxD === 1'b0)
      else
      begin
         $display("no start bit on TxD within %0d cycles of a write to DR", wait_count);
         errors++;
      end
      if (TxD === 1'b0)
      begin
         repeat (BIT_CYCLES / 2) @(negedge clk);
         check_value("TxD start bit", 32'h0, TxD);
         for (int i = 0; i < 8; i++)
         begin
            repeat (BIT_CYCLES) @(negedge clk);
            value[i] = TxD;
         end
         repeat (BIT_CYCLES) @(negedge clk);
         check_value("TxD stop bit", 32'h1, TxD);
      end
   endtask

   task automatic wait_tx_complete();
      logic [31:0] rd;
      int          polls;
      rd    = '0;
      polls = 0;
      while (rd[TSTAT_TC] !== 1'b1 && polls < 4 * BIT_CYCLES)
      begin
         bus_read(REG_TSTAT, rd);
         polls++;
      end
      assert (rd[TSTAT_TC] === 1'b1)
      else
      begin
         $display("transmitter still busy %0d cycles after its frame ended", polls);
         errors++;
      end
   endtask

   task automatic check_line_idle(input int length);
      logic stayed_high;
      stayed_high = 1'b1;
      repeat (length)
      begin
         @(negedge clk);
         if (TxD !== 1'b1)
            stayed_high = 1'b0;
      end
      assert (stayed_high)
      else
      begin
         $display("extra frame on TxD after a write to DR while busy");
         errors++;
      end
   endtask

   task automatic finish_test(input string name);
      if (errors == test_errors)
      begin
         tests_passed++;
         $display("test %s: passed", name);
      end
      else
      begin
         tests_failed++;
         $display("test %s: failed with %0d errors", name, errors - test_errors);
      end
      test_errors = errors;
   endtask

   initial
   begin
      while (cycles < TIMEOUT_CYCLES)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("run stopped after %0d cycles without finishing", TIMEOUT_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   initial
   begin
      logic [31:0] rd;
      logic [31:0] value;
      uart_byte_t  b;
      uart_byte_t  got;
      cs          = 1'b0;
      wen         = 1'b0;
      addr        = '0;
      din         = '0;
      RxD         = 1'b1;  // Idle line
      test_errors = 0;
      wait (reset == 1'b0);

      bus_read(REG_CTRL, rd);
      check_value("CTRL", 32'h0, rd);
      bus_read(REG_CPB, rd);
      check_value("CPB", 32'd217, rd);
      bus_read(REG_TSTAT, rd);
      check_value("TSTAT.TC", 32'h1, rd[TSTAT_TC]);
      bus_read(REG_RSTAT, rd);
      check_value("RSTAT flags and pointers", 32'h8, rd & 32'h0F0F_000F);
      check_counters();
      value = $random(seed);
      bus_write(REG_CTRL, value);
      bus_read(REG_CTRL, rd);
      check_value("CTRL", value, rd);
      value = $random(seed);
      bus_write(REG_CPB, value);
      bus_read(REG_CPB, rd);
      check_value("CPB", value, rd);
      for (int i = 0; i < 4; i++)
      begin
         value = $random(seed);
         bus_write(reg_addr_t'(REG_SCRATCH + i), value);
         bus_read(reg_addr_t'(REG_SCRATCH + i), rd);
         check_value($sformatf("SCRATCH%0d", REG_SCRATCH + i), value, rd);
      end
      bus_write(4'd10, $random(seed));
      bus_read(4'd10, rd);
      check_value("unmapped 10", 32'h0, rd);
      bus_read(4'd11, rd);
      check_value("unmapped 11", 32'h0, rd);
      bus_write(REG_CTRL, 32'h0);
      bus_write(REG_CPB, BIT_CYCLES);
      finish_test("reset and registers");

      bus_write(REG_CTRL, 32'h1 << CTRL_TX_EN);
      for (int i = 0; i < 8; i++)
      begin
         b = $random(seed);
         bus_write(REG_DR, {24'b0, b});
         fork
            capture_tx_frame(got);
            begin
               bus_read(REG_TSTAT, rd);
               check_value("TSTAT.TC during frame", 32'h0, rd[TSTAT_TC]);
               bus_write(REG_DR, $random(seed));  // Dropped while busy
            end
         join
         check_value("TxD byte", b, got);
         wait_tx_complete();
         check_line_idle(2 * BIT_CYCLES);
      end
      finish_test("transmit");

      bus_write(REG_CTRL, 32'h1 << CTRL_RX_EN);
      for (int i = 0; i < 10; i++)
      begin
         b = $random(seed);
         send_frame(b);
         model_receive(b);
      end
      while (exp_q.size() > 0)
         pop_and_check();
      bus_read(REG_RSTAT, rd);
      check_value("RSTAT.NOT_EMPTY", 32'h0, rd[RSTAT_NOT_EMPTY]);
      finish_test("receive in order");

      check_counters();
      bus_write(REG_CTRL, 32'h0);
      for (int i = 0; i < 3; i++)
         send_frame($random(seed));  // Receiver off so nothing is expected
      check_counters();
      bus_read(REG_RSTAT, rd);
      check_value("RSTAT.EMPTY", 32'h1, rd[RSTAT_EMPTY]);
      bus_write(REG_CTRL, 32'h1 << CTRL_RX_EN);
      b = $random(seed);
      send_frame(b);
      model_receive(b);
      check_counters();
      pop_and_check();
      finish_test("counters and enable");

      for (int i = 0; i < 20; i++)
      begin
         b = $random(seed);
         send_frame(b);
         model_receive(b);
      end
      check_counters();
      bus_read(REG_FIFO_FULL_COUNT, rd);
      check_value("FIFO_FULL_COUNT", 32'd4, rd);
      bus_read(REG_RSTAT, rd);
      check_value("RSTAT.FULL", 32'h1, rd[RSTAT_FULL]);
      while (exp_q.size() > 0)
         pop_and_check();
      bus_read(REG_RSTAT, rd);
      check_value("RSTAT.EMPTY", 32'h1, rd[RSTAT_EMPTY]);
      finish_test("overflow");

      // Line held low well past one frame
      @(negedge clk);
      RxD = 1'b0;
      repeat (12 * BIT_CYCLES) @(negedge clk);
      RxD = 1'b1;
      repeat (2 * BIT_CYCLES) @(negedge clk);
      check_counters();
      bus_read(REG_RSTAT, rd);
      check_value("RSTAT.BREAK", 32'h1, rd[RSTAT_BREAK]);
      check_value("RSTAT.EMPTY", 32'h1, rd[RSTAT_EMPTY]);
      b = $random(seed);
      send_frame(b);
      model_receive(b);
      bus_read(REG_RSTAT, rd);
      check_value("RSTAT.BREAK", 32'h0, rd[RSTAT_BREAK]);
      check_counters();
      pop_and_check();
      finish_test("break");

      $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
      if (tests_failed == 0 && errors == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// ==== uart.f ====
common/uart_pkg.sv
verilog/sync_fifo.sv
uart/uart_tx.sv
uart/uart_rx.sv
uart/uart.sv
dv/tb_clock.sv
dv/uart_tb.sv

// ==== Bender.yml ====
package:
  name: uart

sources:
  - common/uart_pkg.sv
  - verilog/sync_fifo.sv
  - uart/uart_tx.sv
  - uart/uart_rx.sv
  - uart/uart.sv
  - target: test
    files:
      - dv/tb_clock.sv
      - dv/uart_tb.sv
